// ==== include/trace_config.svh ====
// trace path constants for widths, packet shape, gap and trigger word; include where needed
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// datapath widths
`define TRACE_XLEN 32
`define TRACE_WORD_W 32
`define TRACE_SEQ_W 16

// packet shape
`define TRACE_PKT_WORDS 4

// idle beats between packets on the transmit stream
`define TRACE_GAP_CYCLES 8

// first word of a received frame that fires the debug trigger ("TRIG")
`define TRACE_TRIGGER_WORD 32'h5452_4947

`endif

// ==== hw/trace_pkg.sv ====
// shared types for the retire trace path; imported by the RTL modules and the testbench
`include "trace_config.svh"

package trace_pkg;

  typedef logic [`TRACE_XLEN-1:0]   xlen_t;        // pc or register value
  typedef logic [`TRACE_WORD_W-1:0] trace_word_t;  // one stream word
  typedef logic [4:0]               reg_addr_t;    // integer register index
  typedef logic [`TRACE_SEQ_W-1:0]  seq_t;         // packet sequence number

  // privilege level of the retiring instruction
  typedef enum logic [1:0] {
    priv_user    = 2'd0,
    priv_super   = 2'd1,
    priv_machine = 2'd3
  } priv_mode_t;

  // packetizer fsm
  typedef enum logic [1:0] {
    pkt_idle,
    pkt_send,
    pkt_gap
  } pkt_state_t;

endpackage

// ==== hw/retire_capture.sv ====
// one-entry buffer for a retired instruction record; stalls the core until the packetizer takes it
`timescale 1ns/1ns

module retire_capture import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // retire strobe and fields from the core
  input  logic        retire,
  input  xlen_t       pc,
  input  trace_word_t instr,
  input  logic        gpr_wen,
  input  reg_addr_t   gpr_addr,
  input  xlen_t       gpr_value,
  input  logic        trap,
  input  priv_mode_t  priv,

  // hand-off to the packetizer
  input  logic        take,
  output logic        stall,
  output logic        rec_pending,
  output xlen_t       rec_pc,
  output trace_word_t rec_instr,
  output logic        rec_gpr_wen,
  output reg_addr_t   rec_gpr_addr,
  output xlen_t       rec_gpr_value,
  output logic        rec_trap,
  output priv_mode_t  rec_priv
);

  logic pending_q;

  //////////////////////////////////////////////////
  // pending flag
  //////////////////////////////////////////////////

  // retire only arrives while stall is low, so it never meets take
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (retire) begin
      pending_q <= 1'b1;
    end else if (take) begin
      pending_q <= 1'b0;
    end
  end

  assign rec_pending = pending_q;
  assign stall       = pending_q;  // core holds off until the buffer drains

  //////////////////////////////////////////////////
  // record buffer
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (retire) begin
      rec_pc        <= pc;
      rec_instr     <= instr;
      rec_gpr_wen   <= gpr_wen;
      rec_gpr_addr  <= gpr_addr;
      rec_gpr_value <= gpr_wen ? gpr_value : '0;  // no write, report zero
      rec_trap      <= trap;
      rec_priv      <= priv;
    end
  end

endmodule

// ==== hw/trace_packetizer.sv ====
// serializes a captured record into a four-word stream packet with sequence number and idle gap
`timescale 1ns/1ns
`include "trace_config.svh"

module trace_packetizer import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // record from the capture buffer
  input  logic        rec_pending,
  input  xlen_t       rec_pc,
  input  trace_word_t rec_instr,
  input  logic        rec_gpr_wen,
  input  reg_addr_t   rec_gpr_addr,
  input  xlen_t       rec_gpr_value,
  input  logic        rec_trap,
  input  priv_mode_t  rec_priv,
  output logic        take,

  // transmit stream
  output trace_word_t tx_data,
  output logic        tx_valid,
  output logic        tx_last,
  input  logic        tx_ready
);

  localparam int unsigned IDX_W = $clog2(`TRACE_PKT_WORDS);
  localparam int unsigned GAP_W = $clog2(`TRACE_GAP_CYCLES);
  localparam int unsigned PAD_W = `TRACE_WORD_W - `TRACE_SEQ_W - 9;

  // idle takes the final gap cycle, so gap itself lasts one less
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`TRACE_GAP_CYCLES - 2);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`TRACE_PKT_WORDS - 1);

  pkt_state_t       state_q;
  logic [IDX_W-1:0] idx_q;
  logic [GAP_W-1:0] gap_q;
  seq_t             seq_q;
  trace_word_t      pkt_q [`TRACE_PKT_WORDS];
  logic             beat;
  logic             last_beat;

  assign take      = (state_q == pkt_idle) && rec_pending;
  assign tx_valid  = (state_q == pkt_send);
  assign tx_data   = pkt_q[idx_q];
  assign tx_last   = tx_valid && (idx_q == IDX_LAST);
  assign beat      = tx_valid && tx_ready;
  assign last_beat = beat && (idx_q == IDX_LAST);

  //////////////////////////////////////////////////
  // packet register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (take) begin
      pkt_q[0] <= rec_pc;
      pkt_q[1] <= rec_instr;
      pkt_q[2] <= rec_gpr_value;
      pkt_q[3] <= {rec_trap, rec_priv, rec_gpr_wen, rec_gpr_addr, {PAD_W{1'b0}}, seq_q};
    end
  end

  //////////////////////////////////////////////////
  // control fsm
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= pkt_idle;
      idx_q   <= '0;
      gap_q   <= '0;
      seq_q   <= '0;
    end else begin
      unique case (state_q)
        pkt_idle: begin
          if (take) begin
            state_q <= pkt_send;
            idx_q   <= '0;
          end
        end
        pkt_send: begin
          if (last_beat) begin
            state_q <= pkt_gap;
            gap_q   <= '0;
            seq_q   <= seq_q + 1'b1;  // wraps
          end else if (beat) begin
            idx_q <= idx_q + 1'b1;
          end
        end
        pkt_gap: begin
          if (gap_q == GAP_LAST) state_q <= pkt_idle;
          else gap_q <= gap_q + 1'b1;
        end
        default: state_q <= pkt_idle;
      endcase
    end
  end

endmodule

// ==== hw/trigger_detect.sv ====
// watches the received word stream and pulses the debug trigger when a frame opens with the trigger word
`timescale 1ns/1ns
`include "trace_config.svh"

module trigger_detect import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  trace_word_t rx_data,
  input  logic        rx_valid,
  input  logic        rx_last,
  output logic        ila_trigger
);

  logic first_q;  // next valid beat opens a frame
  logic hit;

  //////////////////////////////////////////////////
  // frame boundary tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      first_q <= 1'b1;
    end else if (rx_valid) begin
      first_q <= rx_last;  // a last beat re-arms the first-word flag
    end
  end

  // only the opening word of a frame counts
  assign hit = rx_valid && first_q && (rx_data == `TRACE_TRIGGER_WORD);

  //////////////////////////////////////////////////
  // trigger pulse
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ila_trigger <= 1'b0;
    end else begin
      ila_trigger <= hit;  // single cycle, one per matching beat
    end
  end

endmodule

// ==== hw/trace_top.sv ====
// top of the retire trace path; connects capture, packetizer and trigger monitor to the pins
`timescale 1ns/1ns

module trace_top import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // retire link from the core
  input  logic        retire,
  input  xlen_t       pc,
  input  trace_word_t instr,
  input  logic        gpr_wen,
  input  reg_addr_t   gpr_addr,
  input  xlen_t       gpr_value,
  input  logic        trap,
  input  priv_mode_t  priv,
  output logic        stall,

  // transmit stream
  output trace_word_t tx_data,
  output logic        tx_valid,
  output logic        tx_last,
  input  logic        tx_ready,

  // receive stream
  input  trace_word_t rx_data,
  input  logic        rx_valid,
  input  logic        rx_last,
  output logic        ila_trigger
);

  // record hand-off between capture and packetizer
  logic        take;
  logic        rec_pending;
  xlen_t       rec_pc;
  trace_word_t rec_instr;
  logic        rec_gpr_wen;
  reg_addr_t   rec_gpr_addr;
  xlen_t       rec_gpr_value;
  logic        rec_trap;
  priv_mode_t  rec_priv;

  retire_capture u_retire_capture (
    .clk, .rst, .retire, .pc, .instr, .gpr_wen, .gpr_addr, .gpr_value, .trap, .priv,
    .take, .stall, .rec_pending, .rec_pc, .rec_instr, .rec_gpr_wen, .rec_gpr_addr,
    .rec_gpr_value, .rec_trap, .rec_priv
  );

  trace_packetizer u_trace_packetizer (
    .clk, .rst, .rec_pending, .rec_pc, .rec_instr, .rec_gpr_wen, .rec_gpr_addr,
    .rec_gpr_value, .rec_trap, .rec_priv, .take,
    .tx_data, .tx_valid, .tx_last, .tx_ready
  );

  trigger_detect u_trigger_detect (
    .clk, .rst, .rx_data, .rx_valid, .rx_last, .ila_trigger
  );

endmodule

// ==== tests/tb_trace_top.sv ====
// random self-checking testbench for trace_top; models packets and triggers, run via all.f
`timescale 1ns/1ns
`include "trace_config.svh"

module tb_trace_top import trace_pkg::*; ();

  localparam int NUM_RETIRES = 300;
  localparam int NUM_FRAMES  = 200;
  localparam int PKT_WORDS   = `TRACE_PKT_WORDS;
  localparam int GAP_CYCLES  = `TRACE_GAP_CYCLES;
  localparam int MAX_CYCLES  = NUM_RETIRES * (PKT_WORDS + GAP_CYCLES + 2) * 3 + 2000;

  logic        clk;
  logic        rst;
  logic        retire;
  xlen_t       pc;
  trace_word_t instr;
  logic        gpr_wen;
  reg_addr_t   gpr_addr;
  xlen_t       gpr_value;
  logic        trap;
  priv_mode_t  priv;
  logic        stall;
  trace_word_t tx_data;
  logic        tx_valid;
  logic        tx_last;
  logic        tx_ready;
  trace_word_t rx_data;
  logic        rx_valid;
  logic        rx_last;
  logic        ila_trigger;

  // reference model state
  trace_word_t exp_words[$];
  seq_t        model_seq;
  int          retire_count;
  int          pkt_count;
  int          beat_idx;
  int          gap_cnt;
  logic        in_gap;
  logic        hold_valid;
  logic        hold_last;
  trace_word_t hold_data;
  trace_word_t exp_w;
  logic        trig_exp;
  logic        rx_first;
  logic        retire_seen;  // retire strobe in the previous cycle
  int          cycle_cnt;
  logic        run_done;

  trace_top u_trace_top (
    .clk, .rst, .retire, .pc, .instr, .gpr_wen, .gpr_addr, .gpr_value, .trap, .priv,
    .stall, .tx_data, .tx_valid, .tx_last, .tx_ready, .rx_data, .rx_valid, .rx_last,
    .ila_trigger
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic compare_word(input trace_word_t exp, input trace_word_t act, input string what);
    if (act !== exp) begin
      $display("mismatch at %0t ns: %s expected %h got %h", $time, what, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_trigger(input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t ns: ila_trigger expected %b got %b", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_flag(input logic exp, input logic act, input string what);
    if (act !== exp) begin
      $display("mismatch at %0t ns: %s expected %b got %b", $time, what, exp, act);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      trig_exp    = 1'b0;
      rx_first    = 1'b1;
      hold_valid  = 1'b0;
      in_gap      = 1'b0;
      gap_cnt     = 0;
      beat_idx    = 0;
      pkt_count   = 0;
      retire_seen = 1'b0;
    end else begin
      // stall rises the cycle after a retire edge
      if (retire_seen) begin
        compare_flag(1'b1, stall, "stall after retire");
      end
      retire_seen = retire;
      if (!tx_valid) begin
        compare_flag(1'b0, tx_last, "tx_last without tx_valid");
      end
      // words must hold under back-pressure
      if (hold_valid) begin
        compare_flag(1'b1, tx_valid, "tx_valid under back-pressure");
        compare_word(hold_data, tx_data, "tx_data under back-pressure");
        compare_flag(hold_last, tx_last, "tx_last under back-pressure");
      end
      hold_valid = tx_valid && !tx_ready;
      hold_data  = tx_data;
      hold_last  = tx_last;
      if (in_gap) begin
        if (tx_valid) begin
          if (gap_cnt < GAP_CYCLES) begin
            $display("mismatch at %0t ns: gap of %0d idle cycles, expected at least %0d",
                     $time, gap_cnt, GAP_CYCLES);
            abort_run();
          end
          in_gap = 1'b0;
        end else begin
          gap_cnt = gap_cnt + 1;
        end
      end
      if (tx_valid && tx_ready) begin
        if (exp_words.size() == 0) begin
          $display("transmit beat at %0t ns with no retired record behind it", $time);
          abort_run();
        end
        exp_w = exp_words.pop_front();
        compare_word(exp_w, tx_data, "tx_data");
        compare_flag(logic'(beat_idx == PKT_WORDS - 1), tx_last, "tx_last");
        if (beat_idx == PKT_WORDS - 1) begin
          beat_idx  = 0;
          pkt_count = pkt_count + 1;
          in_gap    = 1'b1;
          gap_cnt   = 0;
        end else begin
          beat_idx = beat_idx + 1;
        end
      end
      compare_trigger(trig_exp, ila_trigger);  // pulse one cycle after the beat
      trig_exp = rx_valid && rx_first && (rx_data == `TRACE_TRIGGER_WORD);
      if (rx_valid) rx_first = rx_last;
    end
  end

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////

  task automatic push_expected();
    exp_words.push_back(pc);
    exp_words.push_back(instr);
    exp_words.push_back(gpr_wen ? gpr_value : xlen_t'(0));
    exp_words.push_back({trap, priv, gpr_wen, gpr_addr, 7'd0, model_seq});
    model_seq    = model_seq + 1'b1;
    retire_count = retire_count + 1;
  endtask

  task automatic drive_retires();
    int i;
    for (i = 0; i < NUM_RETIRES; i++) begin
      repeat ($urandom_range(3, 0)) @(posedge clk);
      @(posedge clk);
      #2;
      while (stall) begin  // buffer still full
        @(posedge clk);
        #2;
      end
      pc        = xlen_t'($urandom);
      instr     = trace_word_t'($urandom);
      gpr_wen   = ($urandom_range(1, 0) == 1);
      gpr_addr  = reg_addr_t'($urandom);
      gpr_value = xlen_t'($urandom);
      trap      = ($urandom_range(7, 0) == 0);
      case ($urandom_range(2, 0))
        0: priv = priv_user;
        1: priv = priv_super;
        default: priv = priv_machine;
      endcase
      retire = 1'b1;
      push_expected();
      @(posedge clk);
      #2;
      retire = 1'b0;
    end
  endtask

  task automatic drive_rx();
    int f;
    int w;
    int len;
    for (f = 0; f < NUM_FRAMES; f++) begin
      len = int'($urandom_range(5, 1));
      for (w = 0; w < len; w++) begin
        if ($urandom_range(3, 0) == 0) begin  // idle beat inside the frame
          @(posedge clk);
          #2;
          rx_valid = 1'b0;
          rx_last  = 1'b0;
        end
        @(posedge clk);
        #2;
        rx_valid = 1'b1;
        rx_last  = (w == len - 1);
        if (w == 0) begin
          rx_data = ($urandom_range(2, 0) == 0) ? `TRACE_TRIGGER_WORD : trace_word_t'($urandom);
        end else begin
          // trigger value off the first word must not fire
          rx_data = ($urandom_range(3, 0) == 0) ? `TRACE_TRIGGER_WORD : trace_word_t'($urandom);
        end
      end
      @(posedge clk);
      #2;
      rx_valid = 1'b0;
      rx_last  = 1'b0;
      rx_data  = trace_word_t'($urandom);
      repeat ($urandom_range(2, 0)) @(posedge clk);
    end
  endtask

  task automatic drive_ready();
    while (!run_done) begin
      @(posedge clk);
      #2;
      tx_ready = ($urandom_range(2, 0) != 0);  // ready about two thirds of the time
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(47));
    rst          = 1'b1;
    retire       = 1'b0;
    pc           = '0;
    instr        = '0;
    gpr_wen      = 1'b0;
    gpr_addr     = '0;
    gpr_value    = '0;
    trap         = 1'b0;
    priv         = priv_machine;
    tx_ready     = 1'b0;
    rx_data      = '0;
    rx_valid     = 1'b0;
    rx_last      = 1'b0;
    model_seq    = '0;
    retire_count = 0;
    cycle_cnt    = 0;
    run_done     = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    compare_flag(1'b0, stall, "stall after reset");
    compare_flag(1'b0, tx_valid, "tx_valid after reset");
    compare_flag(1'b0, tx_last, "tx_last after reset");
    compare_trigger(1'b0, ila_trigger);
    fork
      drive_ready();
      begin
        fork
          drive_retires();
          drive_rx();
        join
        while (exp_words.size() != 0) @(posedge clk);
        repeat (GAP_CYCLES + 4) @(posedge clk);
        run_done = 1'b1;
      end
    join
    if (pkt_count == retire_count) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("packet count %0d does not match retire count %0d", pkt_count, retire_count);
      abort_run();
    end
  end

endmodule

// ==== all.f ====
+incdir+include
hw/trace_pkg.sv
hw/retire_capture.sv
hw/trace_packetizer.sv
hw/trigger_detect.sv
hw/trace_top.sv
tests/tb_trace_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the trace path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_trace_top -o sim_trace \
  && ./obj_dir/sim_trace | tee /dev/stderr | grep -q "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
